//--- Makefile
TOP = switch_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- source/egress_scheduler.sv
`timescale 1ns/1ps
`include "switch_consts.svh"

module egress_scheduler (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    wrr_en,
    input  logic [`PORTS-1:0]                       ready,
    input  logic [`PORTS-1:0][`PRIOS-1:0]           pkt_waiting,
    output logic [`PORTS-1:0]                       pop,
    output switch_pkg::prio_t [`PORTS-1:0]          pop_prio,
    input  switch_pkg::word_t [`PORTS-1:0]          pop_data,
    input  logic [`PORTS-1:0]                       pop_last,
    output logic [`PORTS-1:0]                       rd_sop,
    output logic [`PORTS-1:0]                       rd_eop,
    output logic [`PORTS-1:0]                       rd_vld,
    output switch_pkg::word_t [`PORTS-1:0]          rd_data
);

    localparam int WRR_W = $clog2(`WRR_WEIGHT + 1);

    // per output port state
    logic [`PORTS-1:0] streaming;
    logic [`PORTS-1:0] first;
    logic [WRR_W-1:0]  wrr_cnt  [`PORTS];

    logic [`PORTS-1:0] done;
    logic [`PORTS-1:0] wrr_turn;
    logic [`PORTS-1:0] any_waiting;
    switch_pkg::prio_t [`PORTS-1:0] pick;
    logic [WRR_W-1:0]  next_cnt [`PORTS];

    // priority choice for the next packet
    always_comb begin
        for (int p = 0; p < `PORTS; p++) begin
            any_waiting[p] = (pkt_waiting[p] != '0);
            wrr_turn[p] = wrr_en && pkt_waiting[p][1]
                          && (wrr_cnt[p] == WRR_W'(`WRR_WEIGHT));
            if (wrr_turn[p] || !pkt_waiting[p][0]) begin
                pick[p]     = switch_pkg::prio_t'(1);
                next_cnt[p] = '0;
            end else begin
                pick[p] = switch_pkg::prio_t'(0);
                // saturate at the weight until priority 1 gets its turn
                if (wrr_cnt[p] == WRR_W'(`WRR_WEIGHT)) begin
                    next_cnt[p] = wrr_cnt[p];
                end else begin
                    next_cnt[p] = WRR_W'(wrr_cnt[p] + 1'b1);
                end
            end
        end
    end

    // the last pop has come back once pop_last shows after the first pop
    always_comb begin
        for (int p = 0; p < `PORTS; p++) begin
            done[p] = streaming[p] && !first[p] && pop_last[p];
            pop[p]  = streaming[p] && ready[p] && !done[p];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            streaming <= '0;
            first     <= '0;
            pop_prio  <= '0;
            for (int p = 0; p < `PORTS; p++) begin
                wrr_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `PORTS; p++) begin
                if (!streaming[p]) begin
                    if (ready[p] && any_waiting[p]) begin
                        streaming[p] <= 1'b1;
                        first[p]     <= 1'b1;
                        pop_prio[p]  <= pick[p];
                        wrr_cnt[p]   <= next_cnt[p];
                    end
                end else if (pop[p]) begin
                    first[p] <= 1'b0;
                end else if (done[p]) begin
                    streaming[p] <= 1'b0;
                end
            end
        end
    end

    // framing lines up with the registered queue output
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= '0;
            rd_sop <= '0;
        end else begin
            rd_vld <= pop;
            rd_sop <= pop & first;
        end
    end

    assign rd_eop  = rd_vld & pop_last;
    assign rd_data = pop_data;

endmodule

//--- source/packet_parser.sv
`timescale 1ns/1ps
`include "switch_consts.svh"

module packet_parser (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_sop,
    input  logic                                wr_vld,
    input  switch_pkg::word_t                   wr_data,
    output logic                                full,
    output logic [`PORTS-1:0]                   push,
    output switch_pkg::prio_t                   push_prio,
    output switch_pkg::word_t                   push_data,
    output logic                                push_last,
    input  logic [`PORTS-1:0][`PRIOS-1:0]       credit
);

    localparam int CRED_W = $clog2(`QUEUE_DEPTH + 1);

    switch_pkg::header_word_u hdr_in;

    // packet in progress
    logic                 in_payload;
    switch_pkg::port_id_t cur_dest;
    switch_pkg::prio_t    cur_prior;
    switch_pkg::len_t     remaining;

    logic [CRED_W-1:0] cred [`PORTS][`PRIOS];
    logic [`PORTS-1:0][`PRIOS-1:0] take;
    logic any_zero;
    logic take_hdr;
    logic take_word;

    assign hdr_in.raw = wr_data;

    always_comb begin
        any_zero = 1'b0;
        for (int p = 0; p < `PORTS; p++) begin
            for (int q = 0; q < `PRIOS; q++) begin
                if (cred[p][q] == '0) begin
                    any_zero = 1'b1;
                end
            end
        end
    end

    // hold payload on an empty target queue, hold headers on any empty queue
    assign full = in_payload ? (cred[cur_dest][cur_prior] == '0) : any_zero;

    assign take_hdr  = wr_vld && !full && !in_payload && wr_sop;
    assign take_word = wr_vld && !full && in_payload;

    always_comb begin
        for (int p = 0; p < `PORTS; p++) begin
            for (int q = 0; q < `PRIOS; q++) begin
                take[p][q] = take_word && (cur_dest == switch_pkg::port_id_t'(p))
                             && (cur_prior == switch_pkg::prio_t'(q));
            end
        end
    end

    // header decode and payload countdown
    always_ff @(posedge clk) begin
        if (rst) begin
            in_payload <= 1'b0;
            cur_dest   <= '0;
            cur_prior  <= '0;
            remaining  <= '0;
        end else if (take_hdr) begin
            cur_dest   <= hdr_in.hdr.dest;
            cur_prior  <= hdr_in.hdr.prior;
            remaining  <= hdr_in.hdr.length;
            // zero length is dropped
            in_payload <= (hdr_in.hdr.length != '0);
        end else if (take_word) begin
            remaining <= remaining - 1'b1;
            if (remaining == switch_pkg::len_t'(1)) begin
                in_payload <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push <= '0;
        end else begin
            push <= '0;
            if (take_word) begin
                push <= `PORTS'(1) << cur_dest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_word) begin
            push_prio <= cur_prior;
            push_data <= wr_data;
            push_last <= (remaining == switch_pkg::len_t'(1));
        end
    end

    // one word out per take, one word back per credit pulse
    always_ff @(posedge clk) begin
        for (int p = 0; p < `PORTS; p++) begin
            for (int q = 0; q < `PRIOS; q++) begin
                if (rst) begin
                    cred[p][q] <= CRED_W'(`QUEUE_DEPTH);
                end else if (take[p][q] && !credit[p][q]) begin
                    cred[p][q] <= cred[p][q] - 1'b1;
                end else if (credit[p][q] && !take[p][q]) begin
                    cred[p][q] <= cred[p][q] + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/port_queue.sv
`timescale 1ns/1ps
`include "switch_consts.svh"

module port_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  switch_pkg::prio_t   push_prio,
    input  switch_pkg::word_t   push_data,
    input  logic                push_last,
    input  logic                pop,
    input  switch_pkg::prio_t   pop_prio,
    output switch_pkg::word_t   pop_data,
    output logic                pop_last,
    output logic [`PRIOS-1:0]   pkt_waiting,
    output logic [`PRIOS-1:0]   credit
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    // storage, one circular FIFO per priority
    switch_pkg::word_t mem_data [`PRIOS][`QUEUE_DEPTH];
    logic              mem_last [`PRIOS][`QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr  [`PRIOS];
    logic [PTR_W-1:0] rd_ptr  [`PRIOS];
    logic [CNT_W-1:0] pkt_cnt [`PRIOS];

    logic [`PRIOS-1:0] pkt_in;
    logic [`PRIOS-1:0] pkt_out;

    // complete packets enter on a last push and leave on a last pop
    always_comb begin
        for (int q = 0; q < `PRIOS; q++) begin
            pkt_in[q]  = push && push_last && (push_prio == switch_pkg::prio_t'(q));
            pkt_out[q] = pop && (pop_prio == switch_pkg::prio_t'(q)) && mem_last[q][rd_ptr[q]];
            pkt_waiting[q] = (pkt_cnt[q] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[push_prio][wr_ptr[push_prio]] <= push_data;
            mem_last[push_prio][wr_ptr[push_prio]] <= push_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pop_data <= mem_data[pop_prio][rd_ptr[pop_prio]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pop_last <= 1'b0;
        end else if (pop) begin
            pop_last <= mem_last[pop_prio][rd_ptr[pop_prio]];
        end
    end

    // pointers wrap on the power-of-two depth
    always_ff @(posedge clk) begin
        for (int q = 0; q < `PRIOS; q++) begin
            if (rst) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
            end else begin
                if (push && push_prio == switch_pkg::prio_t'(q)) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop && pop_prio == switch_pkg::prio_t'(q)) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < `PRIOS; q++) begin
            if (rst) begin
                pkt_cnt[q] <= '0;
            end else if (pkt_in[q] && !pkt_out[q]) begin
                pkt_cnt[q] <= pkt_cnt[q] + 1'b1;
            end else if (pkt_out[q] && !pkt_in[q]) begin
                pkt_cnt[q] <= pkt_cnt[q] - 1'b1;
            end
        end
    end

    // credit back to the parser, same cycle as pop_data
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= '0;
        end else begin
            credit <= '0;
            if (pop) begin
                credit[pop_prio] <= 1'b1;
            end
        end
    end

endmodule

//--- source/switch_consts.svh
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// output ports on the switch slice
`define PORTS 4

// priority levels, 0 is served first
`define PRIOS 2

// data word width on ingress and egress
`define WORD_W 16

// entries per priority FIFO, also the starting credit count
`define QUEUE_DEPTH 32

// largest legal payload length in words
`define MAX_LEN 31

// priority-0 packets served before a waiting priority-1 packet
`define WRR_WEIGHT 3

`endif

//--- source/switch_pkg.sv
`include "switch_consts.svh"

package switch_pkg;

    // one data word
    typedef logic [`WORD_W-1:0] word_t;

    // output port number
    typedef logic [$clog2(`PORTS)-1:0] port_id_t;

    // priority level
    typedef logic [$clog2(`PRIOS)-1:0] prio_t;

    // payload length in words, zero is illegal
    typedef logic [$clog2(`MAX_LEN + 1)-1:0] len_t;

    // ingress word, seen raw or as header fields
    typedef union packed {
        word_t raw;
        struct packed {
            port_id_t   dest;
            prio_t      prior;
            len_t       length;
            logic [7:0] rsvd;
        } hdr;
    } header_word_u;

endpackage

//--- source/switch_top.sv
`timescale 1ns/1ps
`include "switch_consts.svh"

module switch_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrr_en,
    input  logic                            wr_sop,
    input  logic                            wr_vld,
    input  switch_pkg::word_t               wr_data,
    output logic                            full,
    input  logic [`PORTS-1:0]               ready,
    output logic [`PORTS-1:0]               rd_sop,
    output logic [`PORTS-1:0]               rd_eop,
    output logic [`PORTS-1:0]               rd_vld,
    output switch_pkg::word_t [`PORTS-1:0]  rd_data
);

    // parser to queues
    logic [`PORTS-1:0]              push;
    switch_pkg::prio_t              push_prio;
    switch_pkg::word_t              push_data;
    logic                           push_last;
    logic [`PORTS-1:0][`PRIOS-1:0]  credit;

    // queues to scheduler
    logic [`PORTS-1:0][`PRIOS-1:0]  pkt_waiting;
    logic [`PORTS-1:0]              pop;
    switch_pkg::prio_t [`PORTS-1:0] pop_prio;
    switch_pkg::word_t [`PORTS-1:0] pop_data;
    logic [`PORTS-1:0]              pop_last;

    packet_parser packet_parser_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_sop    (wr_sop),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .full      (full),
        .push      (push),
        .push_prio (push_prio),
        .push_data (push_data),
        .push_last (push_last),
        .credit    (credit)
    );

    for (genvar i = 0; i < `PORTS; i++) begin : g_queue
        port_queue port_queue_inst (
            .clk         (clk),
            .rst         (rst),
            .push        (push[i]),
            .push_prio   (push_prio),
            .push_data   (push_data),
            .push_last   (push_last),
            .pop         (pop[i]),
            .pop_prio    (pop_prio[i]),
            .pop_data    (pop_data[i]),
            .pop_last    (pop_last[i]),
            .pkt_waiting (pkt_waiting[i]),
            .credit      (credit[i])
        );
    end

    egress_scheduler egress_scheduler_inst (
        .clk         (clk),
        .rst         (rst),
        .wrr_en      (wrr_en),
        .ready       (ready),
        .pkt_waiting (pkt_waiting),
        .pop         (pop),
        .pop_prio    (pop_prio),
        .pop_data    (pop_data),
        .pop_last    (pop_last),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data)
    );

endmodule

//--- sources.f
+incdir+source
source/switch_pkg.sv
source/packet_parser.sv
source/port_queue.sv
source/egress_scheduler.sv
source/switch_top.sv
tests/switch_tb.sv

//--- tests/switch_tb.sv
`timescale 1ns/1ps
`include "switch_consts.svh"

module switch_tb;

    localparam int N_PKTS  = 126;
    localparam int TIMEOUT = 200 * N_PKTS + 2000;
    localparam int N_KEYS  = 3 * `PORTS;

    logic clk = 1'b0;
    logic rst;
    logic wrr_en;
    logic wr_sop;
    logic wr_vld;
    switch_pkg::word_t wr_data;
    logic full;
    logic [`PORTS-1:0] ready;
    logic [`PORTS-1:0] rd_sop;
    logic [`PORTS-1:0] rd_eop;
    logic [`PORTS-1:0] rd_vld;
    switch_pkg::word_t [`PORTS-1:0] rd_data;

    // sent packets, indexed by the tag in their first payload word
    int pkt_dest [N_PKTS];
    int pkt_prio [N_PKTS];
    int pkt_len  [N_PKTS];
    int pkt_key  [N_PKTS];
    int pkt_slot [N_PKTS];
    switch_pkg::word_t pkt_data [N_PKTS][`MAX_LEN];

    // order keys: port and priority, or whole port in the ordered tests
    int sent_slot [N_KEYS];
    int rcv_slot  [N_KEYS];
    int sent_total = 0;
    int rcv_total = 0;
    int cycles = 0;
    logic [31:0] seed = 32'h1e4a43c9;
    logic [31:0] rseed;
    logic saw_full;
    logic load_done;
    logic [`PORTS-1:0] ready_seen;
    logic [`PORTS-1:0] in_pkt = '0;
    int cur_tag  [`PORTS];
    int word_idx [`PORTS];
    int load_tag [16];
    int order    [16];

    switch_top switch_top_inst (
        .clk     (clk),
        .rst     (rst),
        .wrr_en  (wrr_en),
        .wr_sop  (wr_sop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        seed = xorshift(seed);
        return int'(seed[15:0]) % n;
    endfunction

    // expected service order at one port, all packets loaded before ready rises
    function automatic void ref_order(input int tags [16], input int n, input logic wrr,
                                      output int seq [16]);
        int hi [16];
        int lo [16];
        int n_hi = 0;
        int n_lo = 0;
        int i_hi = 0;
        int i_lo = 0;
        int streak = 0;
        for (int i = 0; i < n; i++) begin
            if (pkt_prio[tags[i]] == 0) begin
                hi[n_hi] = tags[i];
                n_hi++;
            end else begin
                lo[n_lo] = tags[i];
                n_lo++;
            end
        end
        for (int i = 0; i < n; i++) begin
            if (i_lo < n_lo && (i_hi == n_hi || (wrr && streak == `WRR_WEIGHT))) begin
                seq[i] = lo[i_lo];
                i_lo++;
                streak = 0;
            end else begin
                seq[i] = hi[i_hi];
                i_hi++;
                if (streak < `WRR_WEIGHT) begin
                    streak++;
                end
            end
        end
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // full only changes after a rising edge, so it is settled here
    task automatic send_word(input logic sop, input switch_pkg::word_t data);
        @(negedge clk);
        while (full) begin
            wr_vld   = 1'b0;
            saw_full = 1'b1;
            @(negedge clk);
        end
        wr_vld  = 1'b1;
        wr_sop  = sop;
        wr_data = data;
    endtask

    task automatic send_packet(input int dest, input int prio, input int len,
                               input logic ordered);
        switch_pkg::header_word_u h;
        int tag;
        tag = sent_total;
        pkt_dest[tag] = dest;
        pkt_prio[tag] = prio;
        pkt_len[tag]  = len;
        pkt_key[tag]  = ordered ? 2 * `PORTS + dest : 2 * dest + prio;
        if (!ordered) begin
            pkt_slot[tag] = sent_slot[pkt_key[tag]];
            sent_slot[pkt_key[tag]]++;
        end
        pkt_data[tag][0] = switch_pkg::word_t'(tag);
        for (int i = 1; i < len; i++) begin
            pkt_data[tag][i] = switch_pkg::word_t'(rand_below(65536));
        end
        sent_total++;
        h.raw        = '0;
        h.hdr.dest   = switch_pkg::port_id_t'(dest);
        h.hdr.prior  = switch_pkg::prio_t'(prio);
        h.hdr.length = switch_pkg::len_t'(len);
        send_word(1'b1, h.raw);
        for (int i = 0; i < len; i++) begin
            send_word(1'b0, pkt_data[tag][i]);
        end
        @(negedge clk);
        wr_vld = 1'b0;
        wr_sop = 1'b0;
    endtask

    task automatic begin_test(input logic wrr);
        @(negedge clk);
        rst    = 1'b1;
        wrr_en = wrr;
        ready  = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < N_KEYS; k++) begin
            sent_slot[k] = 0;
            rcv_slot[k]  = 0;
        end
    endtask

    task automatic drain();
        @(negedge clk);
        ready = '1;
        wait (rcv_total == sent_total);
        repeat (4) @(negedge clk);
    endtask

    // priority 1 loaded first, then priority 0, all on port 2
    task automatic ordered_test(input logic wrr);
        begin_test(wrr);
        for (int i = 0; i < 12; i++) begin
            load_tag[i] = sent_total;
            send_packet(2, (i < 4) ? 1 : 0, 1 + rand_below(4), 1'b1);
        end
        ref_order(load_tag, 12, wrr, order);
        for (int i = 0; i < 12; i++) begin
            pkt_slot[order[i]] = i;
        end
        // last packet reaches pkt_waiting
        repeat (4) @(negedge clk);
        drain();
    endtask

    // ready here is what the pops of the cycle just ended saw
    always @(posedge clk) begin
        ready_seen <= ready;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            stop_run("timeout: packets were not delivered within the cycle limit");
        end
    end

    always @(negedge clk) begin
        for (int p = 0; p < `PORTS; p++) begin
            if (!rst && rd_vld[p]) begin
                if (!ready_seen[p]) begin
                    stop_run($sformatf("port %0d gave a word without ready the cycle before", p));
                end
                if (rd_sop[p]) begin
                    if (in_pkt[p]) begin
                        stop_run($sformatf("port %0d started a packet inside a packet", p));
                    end
                    cur_tag[p]  = int'(rd_data[p]);
                    word_idx[p] = 0;
                    in_pkt[p]   = 1'b1;
                    if (cur_tag[p] >= sent_total) begin
                        stop_run($sformatf("port %0d delivered a packet that was never sent", p));
                    end
                    check($sformatf("rd_sop[%0d] port", p), p, pkt_dest[cur_tag[p]]);
                    check($sformatf("rd_data[%0d] packet order", p), pkt_slot[cur_tag[p]],
                          rcv_slot[pkt_key[cur_tag[p]]]);
                    rcv_slot[pkt_key[cur_tag[p]]]++;
                end else if (!in_pkt[p]) begin
                    stop_run($sformatf("port %0d gave a word outside a packet", p));
                end
                if (word_idx[p] >= pkt_len[cur_tag[p]]) begin
                    stop_run($sformatf("port %0d packet ran past its header length", p));
                end
                check($sformatf("rd_data[%0d]", p), 32'(rd_data[p]),
                      32'(pkt_data[cur_tag[p]][word_idx[p]]));
                if (rd_eop[p]) begin
                    check($sformatf("rd_eop[%0d] position", p), word_idx[p] + 1,
                          pkt_len[cur_tag[p]]);
                    in_pkt[p] = 1'b0;
                    rcv_total++;
                end
                word_idx[p]++;
            end else if (!rst && (rd_sop[p] || rd_eop[p])) begin
                stop_run($sformatf("port %0d framing bit set without rd_vld", p));
            end
        end
    end

    initial begin
        rst       = 1'b1;
        wrr_en    = 1'b0;
        wr_sop    = 1'b0;
        wr_vld    = 1'b0;
        wr_data   = '0;
        ready     = '0;
        saw_full  = 1'b0;
        load_done = 1'b0;
        rseed     = xorshift(~seed);

        // one packet of each short length to every port
        begin_test(1'b0);
        ready = '1;
        for (int d = 0; d < `PORTS; d++) begin
            for (int l = 1; l <= 4; l++) begin
                send_packet(d, l % 2, l, 1'b0);
            end
        end
        drain();

        begin_test(1'b0);
        ready = '1;
        repeat (60) begin
            send_packet(rand_below(`PORTS), rand_below(`PRIOS), 1 + rand_below(`MAX_LEN), 1'b0);
        end
        drain();

        ordered_test(1'b0);
        ordered_test(1'b1);

        // 48 words into one 32 entry FIFO with ready low
        begin_test(1'b0);
        saw_full  = 1'b0;
        load_done = 1'b0;
        fork
            begin
                repeat (6) send_packet(1, 0, 8, 1'b0);
                load_done = 1'b1;
            end
            begin
                wait (saw_full || load_done);
                repeat (4) @(negedge clk);
                ready = '1;
            end
        join
        if (!saw_full) begin
            stop_run("full never went high while port 1 priority 0 had no credit left");
        end
        drain();

        begin_test(1'b0);
        load_done = 1'b0;
        fork
            begin
                repeat (20) begin
                    send_packet(rand_below(`PORTS), rand_below(`PRIOS), 1 + rand_below(16), 1'b0);
                end
                load_done = 1'b1;
            end
            begin
                while (!load_done) begin
                    @(negedge clk);
                    rseed = xorshift(rseed);
                    ready = rseed[`PORTS-1:0];
                end
            end
        join
        drain();

        if (rcv_total == sent_total && in_pkt == '0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_run("packets were left undelivered at the end of the run");
        end
    end

endmodule
